// File: tracer_macros.svh
// shared sizing constants: commit port count, queue depth, record field widths

`ifndef TRACER_MACROS_SVH
`define TRACER_MACROS_SVH

// --------------------
// ports and queues
// --------------------
// commit ports acknowledged per cycle
`define NR_COMMIT_PORTS 2
// records held per port queue
`define TRACE_FIFO_DEPTH 4

// --------------------
// record fields
// --------------------
`define TRACE_PC_W 64
`define TRACE_INSN_W 32
// top bit of the cause marks an interrupt
`define TRACE_CAUSE_W 64

`endif

// File: tracer_pkg.sv
// trace types: privilege, hart mode and record kind enums, trace record struct

`include "tracer_macros.svh"

package tracer_pkg;

  // RISC-V privilege encoding as driven by the CSR file
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  // hart mode of a record, debug overrides privilege
  typedef enum logic [1:0] {
    MODE_U = 2'd0,
    MODE_S = 2'd1,
    MODE_M = 2'd2,
    MODE_D = 2'd3
  } trace_mode_e;

  typedef enum logic [1:0] {
    KIND_RETIRE    = 2'd0,
    KIND_EXCEPTION = 2'd1,
    KIND_INTERRUPT = 2'd2
  } trace_kind_e;

  // one commit as seen on the trace stream, port number travels beside it
  typedef struct packed {
    logic [`TRACE_PC_W-1:0]    pc;
    logic [`TRACE_INSN_W-1:0]  insn;
    logic [`TRACE_CAUSE_W-1:0] cause;
    trace_kind_e               kind;
    trace_mode_e               mode;
  } trace_rec_t;

endpackage

// File: trace_encoder.sv
// trace_encoder: sorts one commit port into a trace record and a push strobe

`timescale 1ns/1ns

`include "tracer_macros.svh"

module trace_encoder import tracer_pkg::*; (
  input  logic                      ack_i,
  input  logic [`TRACE_PC_W-1:0]    pc_i,
  input  logic [`TRACE_INSN_W-1:0]  insn_i,
  input  logic                      ex_valid_i,
  input  logic [`TRACE_CAUSE_W-1:0] cause_i,
  input  priv_lvl_e                 priv_lvl_i,
  input  logic                      debug_mode_i,
  output logic                      push_o,
  output trace_rec_t                rec_o
);

  trace_kind_e kind;
  trace_mode_e mode;

  // --------------------
  // record kind
  // --------------------
  always_comb begin
    if (!ex_valid_i) begin
      kind = KIND_RETIRE;
    end else if (cause_i[`TRACE_CAUSE_W-1]) begin
      kind = KIND_INTERRUPT;
    end else begin
      kind = KIND_EXCEPTION;
    end
  end

  // --------------------
  // hart mode
  // --------------------
  always_comb begin
    if (debug_mode_i) begin
      mode = MODE_D;
    end else begin
      case (priv_lvl_i)
        PRIV_LVL_U: mode = MODE_U;
        PRIV_LVL_S: mode = MODE_S;
        // reserved level 2 is reported as machine
        default:    mode = MODE_M;
      endcase
    end
  end

  // commit never stalls, every ack is pushed
  assign push_o = ack_i;

  assign rec_o = '{pc: pc_i, insn: insn_i, cause: cause_i, kind: kind, mode: mode};

endmodule

// File: trace_fifo.sv
// trace_fifo: per-port fall-through record queue with sticky overflow flag

`timescale 1ns/1ns

`include "tracer_macros.svh"

module trace_fifo import tracer_pkg::*; #(
  parameter int unsigned Depth = `TRACE_FIFO_DEPTH
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       push_i,
  input  trace_rec_t rec_i,
  input  logic       pop_i,
  output logic       valid_o,
  output trace_rec_t rec_o,
  output logic       overflow_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);
  localparam logic [PtrW-1:0] LastPtr = PtrW'(Depth - 1);
  localparam logic [CntW-1:0] FullCnt = CntW'(Depth);

  trace_rec_t      mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            overflow_q;

  logic full;
  logic empty;
  logic push_ok;
  logic pop_ok;

  assign full  = (count_q == FullCnt);
  assign empty = (count_q == '0);

  // a pop frees the slot in the same cycle, so a full queue still takes a push
  assign pop_ok  = pop_i & ~empty;
  assign push_ok = push_i & (~full | pop_ok);

  // --------------------
  // pointers and count
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // lost record, held until reset
      if (push_i && !push_ok) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
  end

  assign valid_o    = ~empty;
  assign rec_o      = mem_q[rd_ptr_q];
  assign overflow_o = overflow_q;

endmodule

// File: trace_arbiter.sv
// trace_arbiter: round-robin merge of queue heads onto one valid/ready stream

`timescale 1ns/1ns

`include "tracer_macros.svh"

module trace_arbiter import tracer_pkg::*; #(
  parameter int unsigned NumPorts = `NR_COMMIT_PORTS,
  localparam int unsigned IdxW    = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [NumPorts-1:0] valid_i,
  input  trace_rec_t          rec_i [NumPorts],
  input  logic                ready_i,
  output logic [NumPorts-1:0] pop_o,
  output logic                valid_o,
  output logic [IdxW-1:0]     port_o,
  output trace_rec_t          rec_o
);

  localparam logic [IdxW-1:0] LastIdx = IdxW'(NumPorts - 1);

  logic [IdxW-1:0] ptr_q;
  logic [IdxW-1:0] win_idx;
  logic            win_found;
  logic            xfer;

  // --------------------
  // pick winner
  // --------------------
  // first valid port at or after the pointer, wrapping
  always_comb begin
    int unsigned cand;
    cand      = 0;
    win_idx   = ptr_q;
    win_found = 1'b0;
    for (int unsigned off = 0; off < NumPorts; off++) begin
      cand = int'(ptr_q) + off;
      if (cand >= NumPorts) begin
        cand = cand - NumPorts;
      end
      if (!win_found && valid_i[cand]) begin
        win_found = 1'b1;
        win_idx   = IdxW'(cand);
      end
    end
  end

  assign valid_o = win_found;
  assign port_o  = win_idx;
  assign rec_o   = rec_i[win_idx];
  assign xfer    = win_found & ready_i;

  always_comb begin
    pop_o          = '0;
    pop_o[win_idx] = xfer;
  end

  // pointer moves past the port that just transferred
  // a stalled winner keeps the pointer, so a port filling ahead of it cannot take over
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (xfer) begin
      ptr_q <= (win_idx == LastIdx) ? '0 : win_idx + 1'b1;
    end else if (win_found) begin
      ptr_q <= win_idx;
    end
  end

endmodule

// File: commit_tracer.sv
// commit_tracer: per-port encoders and queues merged into one trace stream

`timescale 1ns/1ns

`include "tracer_macros.svh"

module commit_tracer import tracer_pkg::*; #(
  localparam int unsigned NumPorts = `NR_COMMIT_PORTS,
  localparam int unsigned PortW    = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // commit side
  input  logic [NumPorts-1:0]                      commit_ack_i,
  input  logic [NumPorts-1:0][`TRACE_PC_W-1:0]     commit_pc_i,
  input  logic [NumPorts-1:0][`TRACE_INSN_W-1:0]   commit_insn_i,
  input  logic [NumPorts-1:0]                      commit_ex_valid_i,
  input  logic [NumPorts-1:0][`TRACE_CAUSE_W-1:0]  commit_cause_i,
  input  priv_lvl_e                                priv_lvl_i,
  input  logic                                     debug_mode_i,
  // trace stream
  output logic                                     trace_valid_o,
  input  logic                                     trace_ready_i,
  output logic [PortW-1:0]                         trace_port_o,
  output logic [`TRACE_PC_W-1:0]                   trace_pc_o,
  output logic [`TRACE_INSN_W-1:0]                 trace_insn_o,
  output logic [`TRACE_CAUSE_W-1:0]                trace_cause_o,
  output trace_kind_e                              trace_kind_o,
  output trace_mode_e                              trace_mode_o,
  output logic [NumPorts-1:0]                      overflow_o
);

  logic [NumPorts-1:0] push;
  trace_rec_t          enc_rec  [NumPorts];
  logic [NumPorts-1:0] head_valid;
  trace_rec_t          head_rec [NumPorts];
  logic [NumPorts-1:0] pop;
  trace_rec_t          stream_rec;

  // --------------------
  // per-port path
  // --------------------
  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    trace_encoder u_encoder (
      .ack_i        ( commit_ack_i[p]      ),
      .pc_i         ( commit_pc_i[p]       ),
      .insn_i       ( commit_insn_i[p]     ),
      .ex_valid_i   ( commit_ex_valid_i[p] ),
      .cause_i      ( commit_cause_i[p]    ),
      .priv_lvl_i   ( priv_lvl_i           ),
      .debug_mode_i ( debug_mode_i         ),
      .push_o       ( push[p]              ),
      .rec_o        ( enc_rec[p]           )
    );

    trace_fifo #(
      .Depth ( `TRACE_FIFO_DEPTH )
    ) u_fifo (
      .clk_i      ( clk_i         ),
      .rst_ni     ( rst_ni        ),
      .push_i     ( push[p]       ),
      .rec_i      ( enc_rec[p]    ),
      .pop_i      ( pop[p]        ),
      .valid_o    ( head_valid[p] ),
      .rec_o      ( head_rec[p]   ),
      .overflow_o ( overflow_o[p] )
    );
  end

  // --------------------
  // merge
  // --------------------
  trace_arbiter #(
    .NumPorts ( NumPorts )
  ) u_arbiter (
    .clk_i   ( clk_i         ),
    .rst_ni  ( rst_ni        ),
    .valid_i ( head_valid    ),
    .rec_i   ( head_rec      ),
    .ready_i ( trace_ready_i ),
    .pop_o   ( pop           ),
    .valid_o ( trace_valid_o ),
    .port_o  ( trace_port_o  ),
    .rec_o   ( stream_rec    )
  );

  // record fields out to the stream ports
  assign trace_pc_o    = stream_rec.pc;
  assign trace_insn_o  = stream_rec.insn;
  assign trace_cause_o = stream_rec.cause;
  assign trace_kind_o  = stream_rec.kind;
  assign trace_mode_o  = stream_rec.mode;

endmodule

// File: tb_clock_gen.sv
// testbench clock and active-low reset generator

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 8,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // release shortly after the last reset edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

// File: commit_tracer_chk.sv
// concurrent checks on the trace stream handshake and the arbiter pop vector

`timescale 1ns/1ns

`include "tracer_macros.svh"

module commit_tracer_chk import tracer_pkg::*; (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          trace_valid_i,
  input logic                          trace_ready_i,
  input logic [0:0]                    trace_port_i,
  input logic [`TRACE_PC_W-1:0]        trace_pc_i,
  input logic [`TRACE_INSN_W-1:0]      trace_insn_i,
  input logic [`TRACE_CAUSE_W-1:0]     trace_cause_i,
  input trace_kind_e                   trace_kind_i,
  input trace_mode_e                   trace_mode_i,
  input logic [`NR_COMMIT_PORTS-1:0]   pop_i
);

  // --------------------
  // stream handshake
  // --------------------
  // a stalled record and its port number must hold
  stream_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (trace_valid_i && !trace_ready_i) |=> (trace_valid_i &&
      $stable({trace_port_i, trace_pc_i, trace_insn_i, trace_cause_i,
               trace_kind_i, trace_mode_i})))
    else $error("trace record changed while the stream was stalled");

  reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !trace_valid_i)
    else $error("trace stream valid during reset");

  // --------------------
  // arbiter
  // --------------------
  pop_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(pop_i))
    else $error("more than one queue popped in one cycle");

endmodule

// File: tb_commit_tracer.sv
// testbench top: reads trace cases, drives commit ports and ready, checks the stream

`timescale 1ns/1ns

`include "tracer_macros.svh"

module tb_commit_tracer import tracer_pkg::*; ();

  localparam int unsigned NumPorts  = `NR_COMMIT_PORTS;
  localparam int unsigned PortW     = (NumPorts > 1) ? $clog2(NumPorts) : 1;
  localparam int unsigned Timeout   = 200;
  localparam string       CasesFile = "trace_cases.txt";

  logic                                   clk;
  logic                                   rst_n;
  logic [NumPorts-1:0]                    commit_ack;
  logic [NumPorts-1:0][`TRACE_PC_W-1:0]    commit_pc;
  logic [NumPorts-1:0][`TRACE_INSN_W-1:0]  commit_insn;
  logic [NumPorts-1:0]                    commit_ex_valid;
  logic [NumPorts-1:0][`TRACE_CAUSE_W-1:0] commit_cause;
  priv_lvl_e                              priv_lvl;
  logic                                   debug_mode;
  logic                                   trace_valid;
  logic                                   trace_ready;
  logic [PortW-1:0]                       trace_port;
  logic [`TRACE_PC_W-1:0]                 trace_pc;
  logic [`TRACE_INSN_W-1:0]               trace_insn;
  logic [`TRACE_CAUSE_W-1:0]              trace_cause;
  trace_kind_e                            trace_kind;
  trace_mode_e                            trace_mode;
  logic [NumPorts-1:0]                    overflow;

  // operations in file order, arg is mask, ready level or record target
  byte         op_type_q [$];
  int unsigned op_arg_q  [$];
  int unsigned op_idle_q [$];
  logic [1:0]  op_priv_q [$];
  logic        op_debug_q[$];
  // commit fields, NumPorts entries per commit cycle
  logic [63:0] cm_pc_q   [$];
  logic [31:0] cm_insn_q [$];
  logic        cm_exv_q  [$];
  logic [63:0] cm_cause_q[$];
  // expected records in stream order
  int unsigned exp_port_q [$];
  logic [63:0] exp_pc_q   [$];
  logic [31:0] exp_insn_q [$];
  logic [63:0] exp_cause_q[$];
  logic [1:0]  exp_kind_q [$];
  logic [1:0]  exp_mode_q [$];

  logic [NumPorts-1:0] exp_overflow;
  int unsigned         total_expected;
  int unsigned         value_errors;
  int unsigned         other_errors;
  int unsigned         received;
  bit                  aborted;

  tb_clock_gen #(
    .PeriodNs    ( 8 ),
    .ResetCycles ( 8 )
  ) u_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  commit_tracer u_dut (
    .clk_i             ( clk             ),
    .rst_ni            ( rst_n           ),
    .commit_ack_i      ( commit_ack      ),
    .commit_pc_i       ( commit_pc       ),
    .commit_insn_i     ( commit_insn     ),
    .commit_ex_valid_i ( commit_ex_valid ),
    .commit_cause_i    ( commit_cause    ),
    .priv_lvl_i        ( priv_lvl        ),
    .debug_mode_i      ( debug_mode      ),
    .trace_valid_o     ( trace_valid     ),
    .trace_ready_i     ( trace_ready     ),
    .trace_port_o      ( trace_port      ),
    .trace_pc_o        ( trace_pc        ),
    .trace_insn_o      ( trace_insn      ),
    .trace_cause_o     ( trace_cause     ),
    .trace_kind_o      ( trace_kind      ),
    .trace_mode_o      ( trace_mode      ),
    .overflow_o        ( overflow        )
  );

  bind commit_tracer commit_tracer_chk u_chk (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .trace_valid_i ( trace_valid_o ),
    .trace_ready_i ( trace_ready_i ),
    .trace_port_i  ( trace_port_o  ),
    .trace_pc_i    ( trace_pc_o    ),
    .trace_insn_i  ( trace_insn_o  ),
    .trace_cause_i ( trace_cause_o ),
    .trace_kind_i  ( trace_kind_o  ),
    .trace_mode_i  ( trace_mode_o  ),
    .pop_i         ( pop           )
  );

  task automatic compare_field(string name, logic [63:0] got, logic [63:0] exp);
    assert (got == exp) else begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_parse(int got, int want, byte tag);
    assert (got == want) else begin
      $display("cases file has a malformed %c line", tag);
      other_errors++;
    end
  endtask

  // --------------------
  // cases file
  // --------------------
  task automatic read_cases();
    int          fd;
    int          code;
    byte         tag;
    string       rest;
    int unsigned mask;
    int unsigned exv;
    int unsigned priv;
    int unsigned dbg;
    int unsigned port;
    int unsigned kind;
    int unsigned mode;
    logic [63:0] pc;
    logic [31:0] insn;
    logic [63:0] cause;
    fd = $fopen(CasesFile, "r");
    if (fd == 0) begin
      $display("could not open %s", CasesFile);
      other_errors++;
      aborted = 1'b1;
      return;
    end
    while ($fscanf(fd, " %c", tag) == 1) begin
      case (tag)
        "#": code = $fgets(rest, fd);
        "C": begin
          code = $fscanf(fd, " %h", mask);
          for (int p = 0; p < NumPorts; p++) begin
            code += $fscanf(fd, " %h %h %h %h", pc, insn, exv, cause);
            cm_pc_q.push_back(pc);
            cm_insn_q.push_back(insn);
            cm_exv_q.push_back(exv[0]);
            cm_cause_q.push_back(cause);
          end
          code += $fscanf(fd, " %h %h", priv, dbg);
          check_parse(code, 3 + 4 * NumPorts, tag);
          op_type_q.push_back(tag);
          op_arg_q.push_back(mask);
          op_idle_q.push_back(0);
          op_priv_q.push_back(priv[1:0]);
          op_debug_q.push_back(dbg[0]);
        end
        "R": begin
          code = $fscanf(fd, " %h %h", mask, port);
          check_parse(code, 2, tag);
          op_type_q.push_back(tag);
          op_arg_q.push_back(mask);
          op_idle_q.push_back(port);
          op_priv_q.push_back(2'd0);
          op_debug_q.push_back(1'b0);
        end
        "W": begin
          op_type_q.push_back(tag);
          op_arg_q.push_back(exp_port_q.size());
          op_idle_q.push_back(0);
          op_priv_q.push_back(2'd0);
          op_debug_q.push_back(1'b0);
        end
        "E": begin
          code = $fscanf(fd, " %h %h %h %h %h %h", port, pc, insn, cause, kind, mode);
          check_parse(code, 6, tag);
          exp_port_q.push_back(port);
          exp_pc_q.push_back(pc);
          exp_insn_q.push_back(insn);
          exp_cause_q.push_back(cause);
          exp_kind_q.push_back(kind[1:0]);
          exp_mode_q.push_back(mode[1:0]);
        end
        "O": begin
          code = $fscanf(fd, " %h", mask);
          check_parse(code, 1, tag);
          exp_overflow = NumPorts'(mask);
        end
        default: begin
          $display("cases file has an unknown line type %c", tag);
          other_errors++;
          code = $fgets(rest, fd);
        end
      endcase
    end
    $fclose(fd);
    total_expected = exp_port_q.size();
  endtask

  // --------------------
  // stimulus
  // --------------------
  task automatic drive_commit(int unsigned mask, logic [1:0] priv, logic dbg);
    for (int p = 0; p < NumPorts; p++) begin
      commit_ack[p]      = mask[p];
      commit_pc[p]       = cm_pc_q.pop_front();
      commit_insn[p]     = cm_insn_q.pop_front();
      commit_ex_valid[p] = cm_exv_q.pop_front();
      commit_cause[p]    = cm_cause_q.pop_front();
    end
    priv_lvl   = priv_lvl_e'(priv);
    debug_mode = dbg;
    @(posedge clk);
    #1;
    commit_ack = '0;
  endtask

  task automatic hold_ready(int unsigned level, int unsigned idle);
    trace_ready = level[0];
    repeat (idle) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_records(int unsigned target);
    int unsigned cycles;
    cycles = 0;
    while (received < target && cycles < Timeout) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (received < target) begin
      $display("timeout: no record arrived within %0d cycles, %0d of %0d received",
               Timeout, received, target);
      other_errors++;
      aborted = 1'b1;
    end
  endtask

  // --------------------
  // monitor
  // --------------------
  task automatic check_record();
    assert (exp_port_q.size() != 0) else begin
      $display("unexpected record from port %0d with no expected record left", trace_port);
      other_errors++;
    end
    if (exp_port_q.size() != 0) begin
      compare_field("trace_port_o", 64'(trace_port), 64'(exp_port_q.pop_front()));
      compare_field("trace_pc_o", trace_pc, exp_pc_q.pop_front());
      compare_field("trace_insn_o", 64'(trace_insn), 64'(exp_insn_q.pop_front()));
      compare_field("trace_cause_o", trace_cause, exp_cause_q.pop_front());
      compare_field("trace_kind_o", 64'(trace_kind), 64'(exp_kind_q.pop_front()));
      compare_field("trace_mode_o", 64'(trace_mode), 64'(exp_mode_q.pop_front()));
      received++;
    end
  endtask

  // stream is stable between the driving edge and the transfer edge
  always @(negedge clk) begin
    if (rst_n === 1'b1 && trace_valid === 1'b1 && trace_ready === 1'b1) begin
      check_record();
    end
  end

  initial begin
    int unsigned cycles;
    commit_ack      = '0;
    commit_pc       = '0;
    commit_insn     = '0;
    commit_ex_valid = '0;
    commit_cause    = '0;
    priv_lvl        = PRIV_LVL_M;
    debug_mode      = 1'b0;
    trace_ready     = 1'b0;
    exp_overflow    = '0;
    total_expected  = 0;
    value_errors    = 0;
    other_errors    = 0;
    received        = 0;
    aborted         = 1'b0;
    read_cases();
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < Timeout) begin
      @(posedge clk);
      cycles++;
    end
    #1;
    if (rst_n !== 1'b1) begin
      $display("timeout: reset was never released");
      other_errors++;
      aborted = 1'b1;
    end
    for (int i = 0; i < op_type_q.size(); i++) begin
      if (!aborted) begin
        case (op_type_q[i])
          "C":     drive_commit(op_arg_q[i], op_priv_q[i], op_debug_q[i]);
          "R":     hold_ready(op_arg_q[i], op_idle_q[i]);
          default: wait_records(op_arg_q[i]);
        endcase
      end
    end
    if (!aborted) begin
      wait_records(total_expected);
      // a few quiet cycles catch any extra record
      repeat (4) @(posedge clk);
      #1;
      compare_field("overflow_o", 64'(overflow), 64'(exp_overflow));
    end
    $display("errors: %0d value mismatches, %0d other failures, %0d of %0d records checked",
             value_errors, other_errors, received, total_expected);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: trace_cases.txt
# C mask pc0 insn0 exv0 cause0 pc1 insn1 exv1 cause1 priv debug | R ready idle | W drain
# E port pc insn cause kind mode | O overflow; hex; kind 0 ret 1 exc 2 irq; mode 0 U 1 S 2 M 3 D
R 1 0
C 1 80000000 00000013 0 0 0 0 0 0 3 0
C 1 80000004 00100093 0 0 0 0 0 0 1 0
C 1 80000008 00200113 0 0 0 0 0 0 0 0
C 2 0 0 0 0 8000000c 00300193 0 0 3 0
E 0 80000000 00000013 0 0 2
E 0 80000004 00100093 0 0 1
E 0 80000008 00200113 0 0 0
E 1 8000000c 00300193 0 0 2
W
# exception, interrupt and debug mode
C 1 80000100 0000006f 1 2 0 0 0 0 3 0
C 2 0 0 0 0 80000104 00000073 1 8000000000000007 1 0
C 1 80000108 00100073 0 0 0 0 0 0 0 1
C 2 0 0 0 0 8000010c 00000000 1 3 3 1
E 0 80000100 0000006f 2 1 2
E 1 80000104 00000073 8000000000000007 2 1
E 0 80000108 00100073 0 0 3
E 1 8000010c 00000000 3 1 3
W
# simultaneous pairs, second pair starts at port 1
C 3 80000200 00a00513 0 0 80000300 00b00593 0 0 3 0
E 0 80000200 00a00513 0 0 2
E 1 80000300 00b00593 0 0 2
W
C 1 80000204 00c00613 0 0 0 0 0 0 3 0
E 0 80000204 00c00613 0 0 2
W
C 3 80000208 00d00693 0 0 80000304 00e00713 0 0 1 0
E 1 80000304 00e00713 0 0 1
E 0 80000208 00d00693 0 0 1
W
# back-pressure, drain alternates from port 1
R 0 0
C 3 80000400 01000793 0 0 80000500 01100813 0 0 3 0
C 1 80000404 01200893 0 0 0 0 0 0 3 0
C 2 0 0 0 0 80000504 01300913 0 0 3 0
C 3 80000408 01400993 0 0 80000508 01500a13 0 0 3 0
R 0 3
R 1 0
E 1 80000500 01100813 0 0 2
E 0 80000400 01000793 0 0 2
E 1 80000504 01300913 0 0 2
E 0 80000404 01200893 0 0 2
E 1 80000508 01500a13 0 0 2
E 0 80000408 01400993 0 0 2
W
# port 0 overflow, fifth record is lost
R 0 0
C 1 80000600 02000b13 0 0 0 0 0 0 0 0
C 1 80000604 02100b93 0 0 0 0 0 0 0 0
C 1 80000608 02200c13 0 0 0 0 0 0 0 0
C 1 8000060c 02300c93 0 0 0 0 0 0 0 0
C 1 80000610 02400d13 0 0 0 0 0 0 0 0
R 0 2
R 1 0
E 0 80000600 02000b13 0 0 0
E 0 80000604 02100b93 0 0 0
E 0 80000608 02200c13 0 0 0
E 0 8000060c 02300c93 0 0 0
W
O 1

// File: list.f
+incdir+.
tracer_pkg.sv
trace_encoder.sv
trace_fifo.sv
trace_arbiter.sv
commit_tracer.sv
tb_clock_gen.sv
commit_tracer_chk.sv
tb_commit_tracer.sv

// File: Makefile
# Verilator build and run of the commit tracer testbench

TOP := tb_commit_tracer
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

obj_dir/V$(TOP): list.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
	  echo "test failed"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
	  echo "test failed, run ended without a result"; exit 1; \
	else \
	  echo "test passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
